/* hdl/fifo_cfg.svh */
`ifndef FIFO_CFG_SVH
`define FIFO_CFG_SVH

// --------------------------------------------------
// Global FIFO configuration
// --------------------------------------------------

// Number of entries in the storage array
`define FIFO_DEPTH 4

// Item width in bits
`define FIFO_WIDTH 8

// 1 lets a push go straight to the output stage when the array is empty
`define FIFO_BYPASS 1

// Array index width, never below one bit
`define FIFO_ADDR_W ((`FIFO_DEPTH > 1) ? $clog2(`FIFO_DEPTH) : 1)

`endif

/* hdl/fifo_pkg.sv */
`include "fifo_cfg.svh"

package fifo_pkg;

  // One data item
  typedef logic [`FIFO_WIDTH-1:0] fifo_word_t;

  // Index into the storage array
  typedef logic [`FIFO_ADDR_W-1:0] fifo_addr_t;

  // Items held in the array, 0 up to FIFO_DEPTH
  // One extra bit so that a full array is representable
  typedef logic [`FIFO_ADDR_W:0] fifo_count_t;

  // Write command from the push side
  typedef struct packed {
    logic       en;
    fifo_addr_t addr;
    fifo_word_t data;
  } fifo_ram_wr_t;

  // Read command from the pop side
  // en marks that the entry at addr is consumed
  typedef struct packed {
    logic       en;
    fifo_addr_t addr;
  } fifo_ram_rd_t;

endpackage

/* hdl/fifo_push_ctrl.sv */
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_push_ctrl import fifo_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  // Push port
  input  logic         push_valid,
  output logic         push_ready,
  input  fifo_word_t   push_data,

  // Bypass towards the pop controller
  input  logic         bypass_ready,
  output logic         bypass_valid,
  output fifo_word_t   bypass_data,

  // Array write and occupancy feedback
  output fifo_ram_wr_t ram_wr,
  input  logic         ram_full
);

  logic       push_beat;
  logic       wr_en;
  fifo_addr_t wr_addr;

  // --------------------------------------------------
  // Flow control
  // --------------------------------------------------

  // Ready only looks at the registered full level
  assign push_ready = !ram_full;
  assign push_beat  = push_valid && push_ready;

  // --------------------------------------------------
  // Steering between bypass and array
  // --------------------------------------------------

  if (`FIFO_BYPASS != 0) begin : gen_bypass
    // Offer every accepted beat to the output stage
    assign bypass_valid = push_beat;
    assign bypass_data  = push_data;
    // Array only takes what the bypass turns down
    assign wr_en        = push_beat && !bypass_ready;
  end else begin : gen_no_bypass
    assign bypass_valid = 1'b0;
    assign bypass_data  = '0;
    assign wr_en        = push_beat;
  end

  assign ram_wr = '{en: wr_en, addr: wr_addr, data: push_data};

  // Write address wraps at the last entry, stays at zero for a single entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_addr <= '0;
    end else if (wr_en) begin
      if (wr_addr == fifo_addr_t'(`FIFO_DEPTH - 1)) begin
        wr_addr <= '0;
      end else begin
        wr_addr <= wr_addr + fifo_addr_t'(1);
      end
    end
  end

endmodule

/* hdl/fifo_pop_ctrl.sv */
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_pop_ctrl import fifo_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  // Pop port
  output logic         pop_valid,
  input  logic         pop_ready,
  output fifo_word_t   pop_data,

  // Bypass from the push controller
  input  logic         bypass_valid,
  output logic         bypass_ready,
  input  fifo_word_t   bypass_data,

  // Array read side
  input  logic         ram_empty,
  output fifo_ram_rd_t ram_rd,
  input  fifo_word_t   ram_rd_data
);

  // Output staging entry
  logic       stage_valid;
  fifo_word_t stage_data;

  // Refill decode
  logic       load_slot;
  logic       load_ram;
  logic       load_byp;

  fifo_addr_t rd_addr;

  // --------------------------------------------------
  // Refill choice
  // --------------------------------------------------

  // Staging can take a new item when empty or leaving this cycle
  assign load_slot = !stage_valid || pop_ready;

  // Array goes first so older items leave first
  assign load_ram  = load_slot && !ram_empty;

  // Bypass only when nothing older is waiting in the array
  assign bypass_ready = load_slot && ram_empty;
  assign load_byp     = bypass_ready && bypass_valid;

  // Consumes the head entry of the array
  assign ram_rd = '{en: load_ram, addr: rd_addr};

  // --------------------------------------------------
  // Staging register
  // --------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else if (load_slot) begin
      // Drops to empty on a pop with nothing to refill
      stage_valid <= load_ram || load_byp;
    end
  end

  // Payload only, qualified by stage_valid
  always_ff @(posedge clk) begin
    if (load_ram) begin
      stage_data <= ram_rd_data;
    end else if (load_byp) begin
      stage_data <= bypass_data;
    end
  end

  // Pop valid is a flop output, independent of pop_ready
  assign pop_valid = stage_valid;
  assign pop_data  = stage_data;

  // --------------------------------------------------
  // Read address
  // --------------------------------------------------

  // Same wrap rule as the write side
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (load_ram) begin
      if (rd_addr == fifo_addr_t'(`FIFO_DEPTH - 1)) begin
        rd_addr <= '0;
      end else begin
        rd_addr <= rd_addr + fifo_addr_t'(1);
      end
    end
  end

endmodule

/* hdl/fifo_flop_ram.sv */
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_flop_ram import fifo_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  // Write command from the push side
  input  fifo_ram_wr_t ram_wr,

  // Read port, zero latency
  input  fifo_addr_t   rd_addr,
  output fifo_word_t   rd_data
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  fifo_word_t mem [`FIFO_DEPTH];

  // Entries clear on reset
  // Written at the edge when the command is enabled
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem <= '{default: '0};
    end else if (ram_wr.en) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Plain mux on the read address
  // A write to the same entry shows up after the edge
  assign rd_data = mem[rd_addr];

endmodule

/* hdl/fifo_occupancy.sv */
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_occupancy import fifo_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,

  // Write and read commands to the array
  input  fifo_ram_wr_t ram_wr,
  input  fifo_ram_rd_t ram_rd,

  // Occupancy and levels
  output fifo_count_t  ram_count,
  output logic         ram_full,
  output logic         ram_empty
);

  fifo_count_t count_next;

  // Up on a write, down on a read
  // Both together cancel out
  always_comb begin
    count_next = ram_count;
    case ({ram_wr.en, ram_rd.en})
      2'b10:   count_next = ram_count + fifo_count_t'(1);
      2'b01:   count_next = ram_count - fifo_count_t'(1);
      default: count_next = ram_count;
    endcase
  end

  // Levels come from the next count so they line up with ram_count
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_count <= '0;
      ram_full  <= 1'b0;
      ram_empty <= 1'b1;
    end else begin
      ram_count <= count_next;
      ram_full  <= (count_next == fifo_count_t'(`FIFO_DEPTH));
      ram_empty <= (count_next == '0);
    end
  end

endmodule

/* hdl/fifo_bypass_top.sv */
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_bypass_top import fifo_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // Push port
  input  logic        push_valid,
  output logic        push_ready,
  input  fifo_word_t  push_data,

  // Pop port
  output logic        pop_valid,
  input  logic        pop_ready,
  output fifo_word_t  pop_data,

  // Items currently in the array
  output fifo_count_t ram_count
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  fifo_ram_wr_t ram_wr;
  fifo_ram_rd_t ram_rd;
  fifo_word_t   ram_rd_data;
  logic         ram_full;
  logic         ram_empty;

  // Bypass between the two controllers
  logic         bypass_valid;
  logic         bypass_ready;
  fifo_word_t   bypass_data;

  fifo_push_ctrl push_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .push_valid   (push_valid),
    .push_ready   (push_ready),
    .push_data    (push_data),
    .bypass_ready (bypass_ready),
    .bypass_valid (bypass_valid),
    .bypass_data  (bypass_data),
    .ram_wr       (ram_wr),
    .ram_full     (ram_full)
  );

  fifo_occupancy occupancy_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .ram_wr    (ram_wr),
    .ram_rd    (ram_rd),
    .ram_count (ram_count),
    .ram_full  (ram_full),
    .ram_empty (ram_empty)
  );

  // Read address comes out of the pop command
  fifo_flop_ram flop_ram_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .ram_wr  (ram_wr),
    .rd_addr (ram_rd.addr),
    .rd_data (ram_rd_data)
  );

  fifo_pop_ctrl pop_ctrl_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .pop_valid    (pop_valid),
    .pop_ready    (pop_ready),
    .pop_data     (pop_data),
    .bypass_valid (bypass_valid),
    .bypass_ready (bypass_ready),
    .bypass_data  (bypass_data),
    .ram_empty    (ram_empty),
    .ram_rd       (ram_rd),
    .ram_rd_data  (ram_rd_data)
  );

endmodule

/* tb/fifo_bypass_tb.sv */
`timescale 1ns/1ps

`include "fifo_cfg.svh"

module fifo_bypass_tb import fifo_pkg::*; ;

  localparam int PERIOD = 100;
  localparam int RESET_CYCLES = 16;
  localparam int DRAIN_CYCLES = 16;
  localparam int NUM_STEPS = 6;

  // Input modes of a table row
  localparam logic [1:0] MODE_LOW  = 2'd0;
  localparam logic [1:0] MODE_HIGH = 2'd1;
  localparam logic [1:0] MODE_RAND = 2'd2;

  // One table row, stimulus first, then the levels expected in its last cycle
  typedef struct packed {
    logic [1:0]  push_mode;
    logic        rand_data;
    fifo_word_t  data;
    logic [1:0]  pop_mode;
    logic [15:0] reps;
    logic        chk_end;
    fifo_count_t end_count;
    logic        end_push_ready;
    logic        end_pop_valid;
  } step_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        push_valid;
  logic        push_ready;
  fifo_word_t  push_data;
  logic        pop_valid;
  logic        pop_ready;
  fifo_word_t  pop_data;
  fifo_count_t ram_count;

  step_t       steps [NUM_STEPS];
  fifo_word_t  ref_q [$];
  logic [31:0] lfsr_state = 32'hb8824b78;
  logic        hold_beat = 1'b0;
  int          error_count = 0;
  int          test_errs = 0;
  int          tests_failed = 0;
  int          limit_cycles = 0;

  fifo_bypass_top dut_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .ram_count  (ram_count)
  );

  always #(PERIOD / 2) clk = ~clk;

  // --------------------------------------------------
  // Random bits and result compares
  // --------------------------------------------------

  // Galois form, shifts right
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h80200003;
    end
    return s >> 1;
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic note_error();
    error_count++;
    test_errs++;
  endtask

  task automatic check_word(input string name, input fifo_word_t exp, input fifo_word_t act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %0h got %0h", $time, name, exp, act);
      note_error();
    end
  endtask

  task automatic check_count(input string name, input fifo_count_t exp, input fifo_count_t act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %0d got %0d", $time, name, exp, act);
      note_error();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED t=%0t %s expected %b got %b", $time, name, exp, act);
      note_error();
    end
  endtask

  // --------------------------------------------------
  // Table rows, drive and sample
  // --------------------------------------------------

  function automatic step_t make_step(
    input logic [1:0] push_mode, input logic rand_data, input fifo_word_t data,
    input logic [1:0] pop_mode, input int reps, input logic chk_end,
    input int end_count, input logic end_push_ready, input logic end_pop_valid
  );
    step_t s;
    s.push_mode      = push_mode;
    s.rand_data      = rand_data;
    s.data           = data;
    s.pop_mode       = pop_mode;
    s.reps           = 16'(reps);
    s.chk_end        = chk_end;
    s.end_count      = fifo_count_t'(end_count);
    s.end_push_ready = end_push_ready;
    s.end_pop_valid  = end_pop_valid;
    return s;
  endfunction

  function automatic string step_name(input int idx);
    case (idx)
      0:       return "bypass push";
      1:       return "bypass latency";
      2:       return "fill to full";
      3:       return "order on drain";
      4:       return "mixed traffic";
      default: return "final drain";
    endcase
  endfunction

  task automatic drive_step(input step_t s);
    logic       b;
    fifo_word_t d;
    // A stalled beat keeps its data, an idle row withdraws it
    if (hold_beat && s.push_mode != MODE_LOW) begin
      push_valid = 1'b1;
    end else begin
      if (s.push_mode == MODE_RAND) begin
        take_bit(b);
        push_valid = b;
      end else begin
        push_valid = (s.push_mode == MODE_HIGH);
      end
      if (s.rand_data) begin
        for (int i = 0; i < `FIFO_WIDTH; i++) begin
          take_bit(b);
          d[i] = b;
        end
        push_data = d;
      end else begin
        push_data = s.data;
      end
    end
    if (s.pop_mode == MODE_RAND) begin
      take_bit(b);
      pop_ready = b;
    end else begin
      pop_ready = (s.pop_mode == MODE_HIGH);
    end
  endtask

  // Staging holds the queue head, the array holds the rest
  task automatic sample_cycle();
    int          size;
    fifo_count_t exp_count;
    fifo_word_t  head;
    size = ref_q.size();
    if (size == 0) begin
      exp_count = '0;
    end else begin
      exp_count = fifo_count_t'(size - 1);
    end
    check_bit("pop_valid", size != 0, pop_valid);
    check_bit("push_ready", size <= `FIFO_DEPTH, push_ready);
    check_count("ram_count", exp_count, ram_count);
    // Transfers that happen on the coming edge
    if (pop_valid && pop_ready) begin
      if (size == 0) begin
        $display("Error at t=%0t: an item was popped that was never pushed", $time);
        note_error();
      end else begin
        head = ref_q.pop_front();
        check_word("pop_data", head, pop_data);
      end
    end
    if (push_valid && push_ready) begin
      ref_q.push_back(push_data);
    end
    hold_beat = push_valid && !push_ready;
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------

  initial begin
    wait (limit_cycles != 0);
    #(limit_cycles * PERIOD);
    $display("Timeout: the run did not finish within %0d cycles", limit_cycles);
    $display("Some tests failed");
    $finish;
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    int total;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    rst_n      = 1'b0;

    // Bypass push, then the item shows one cycle later with an empty array
    steps[0] = make_step(MODE_HIGH, 1'b0, fifo_word_t'(8'ha5), MODE_HIGH, 1, 1'b1, 0, 1'b1, 1'b0);
    steps[1] = make_step(MODE_LOW, 1'b0, '0, MODE_HIGH, 1, 1'b1, 0, 1'b1, 1'b1);
    // Staging plus a full array, then pushes stall
    steps[2] = make_step(MODE_HIGH, 1'b1, '0, MODE_LOW, `FIFO_DEPTH + 3, 1'b1,
                         `FIFO_DEPTH, 1'b0, 1'b1);
    steps[3] = make_step(MODE_LOW, 1'b0, '0, MODE_HIGH, `FIFO_DEPTH + 2, 1'b1, 0, 1'b1, 1'b0);
    steps[4] = make_step(MODE_RAND, 1'b1, '0, MODE_RAND, 400, 1'b0, 0, 1'b0, 1'b0);
    steps[5] = make_step(MODE_LOW, 1'b0, '0, MODE_HIGH, `FIFO_DEPTH + 3, 1'b1, 0, 1'b1, 1'b0);

    total = RESET_CYCLES + DRAIN_CYCLES;
    foreach (steps[i]) begin
      total += int'(steps[i].reps);
    end
    limit_cycles = total * 2;

    repeat (RESET_CYCLES) @(posedge clk);
    #1 rst_n = 1'b1;

    // Reset levels
    @(negedge clk);
    test_errs = 0;
    check_bit("pop_valid", 1'b0, pop_valid);
    check_bit("push_ready", 1'b1, push_ready);
    check_count("ram_count", '0, ram_count);
    if (test_errs != 0) tests_failed++;
    $display("Test reset state finished with %0d errors", test_errs);

    foreach (steps[i]) begin
      test_errs = 0;
      for (int r = 0; r < int'(steps[i].reps); r++) begin
        @(posedge clk);
        #1;
        drive_step(steps[i]);
        @(negedge clk);
        sample_cycle();
      end
      if (steps[i].chk_end) begin
        check_count("ram_count", steps[i].end_count, ram_count);
        check_bit("push_ready", steps[i].end_push_ready, push_ready);
        check_bit("pop_valid", steps[i].end_pop_valid, pop_valid);
      end
      if (test_errs != 0) tests_failed++;
      $display("Test %s finished with %0d errors", step_name(i), test_errs);
    end

    if (ref_q.size() != 0) begin
      $display("Error: %0d items were pushed but never popped", ref_q.size());
      error_count++;
    end

    $display("Tests run %0d, tests failed %0d, check errors %0d",
             NUM_STEPS + 1, tests_failed, error_count);
    if (error_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+hdl
hdl/fifo_pkg.sv
hdl/fifo_push_ctrl.sv
hdl/fifo_pop_ctrl.sv
hdl/fifo_flop_ram.sv
hdl/fifo_occupancy.sv
hdl/fifo_bypass_top.sv
tb/fifo_bypass_tb.sv

/* Bender.yml */
package:
  name: fifo_bypass

sources:
  # Synthesizable design, package first
  - include_dirs:
      - hdl
    files:
      - hdl/fifo_pkg.sv
      - hdl/fifo_push_ctrl.sv
      - hdl/fifo_pop_ctrl.sv
      - hdl/fifo_flop_ram.sv
      - hdl/fifo_occupancy.sv
      - hdl/fifo_bypass_top.sv

  # Simulation only
  - target: test
    include_dirs:
      - hdl
    files:
      - tb/fifo_bypass_tb.sv
